// ==== common/fetch_beat_if.sv ====
`timescale 1ns/1ps

// One returned bus beat, as seen by the queue and the assembly logic
interface fetch_beat_if;
	import frontend_pkg::*;

	// Raw bus word, passed through without a register
	word_t  data;

	// Bus error for the whole word
	logic   err;

	// Which halfwords of the word belong to the program stream
	hwvld_t hwvld;

	// High for a beat that arrived and is not being thrown away after a jump
	// There is no ready here, so a live beat is always taken that cycle
	logic   live;

	modport source (
		output data,
		output err,
		output hwvld,
		output live
	);

	modport sink (
		input data,
		input err,
		input hwvld,
		input live
	);

endinterface

// ==== common/frontend_pkg.sv ====
// Shared widths and types for the instruction fetch front end
package frontend_pkg;

	// ----------------------------------------
	// Widths
	// ----------------------------------------

	// Fetch and jump addresses are byte addresses
	localparam int w_addr = 32;

	// The bus always moves one full word per beat
	localparam int w_data = 32;

	// RISC-V instructions are built from 16-bit parcels
	localparam int w_hw = 16;

	// ----------------------------------------
	// Types
	// ----------------------------------------

	typedef logic [w_addr-1:0] addr_t;
	typedef logic [w_data-1:0] word_t;
	typedef logic [w_hw-1:0]   hw_t;

	// Bit 0 flags the lower halfword of a word, bit 1 the upper one
	typedef logic [1:0] hwvld_t;

	// Halfword count, 0 to 3, for the CIR and its spare halfword
	typedef logic [1:0] level_t;

	// Number of bus fetches in flight, never more than 2
	typedef logic [1:0] pend_t;

endpackage

// ==== common/queue_head_if.sv ====
`timescale 1ns/1ps

// Head of the prefetch queue and the feedback from instruction assembly
interface queue_head_if;
	import frontend_pkg::*;

	word_t  head_data;
	logic   head_err;
	hwvld_t head_hwvld;
	logic   empty;
	logic   full;
	logic   almost_full;

	// Head entry leaves the queue at the next edge
	logic   pop;

	// The live beat went straight into the CIR and is not to be queued
	logic   bypass;

	modport head (
		output head_data, head_err, head_hwvld,
		output empty, full, almost_full,
		input  pop, bypass
	);

	modport consumer (
		input  head_data, head_err, head_hwvld, empty,
		output pop, bypass
	);

	// Fetch side only needs the fill state to throttle new requests
	modport stall (
		input full, almost_full
	);

endinterface

// ==== fetch/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl #(
	parameter frontend_pkg::addr_t reset_vector = 32'h0000_0000,
	parameter bit                  extension_c  = 1'b1,
	parameter int                  fifo_depth   = 2
) (
	input  logic                clk,
	input  logic                rst_n,
	output frontend_pkg::addr_t mem_addr,
	output logic                mem_addr_vld,
	input  logic                mem_addr_rdy,
	input  frontend_pkg::word_t mem_data,
	input  logic                mem_data_err,
	input  logic                mem_data_vld,
	input  frontend_pkg::addr_t jump_target,
	input  logic                jump_target_vld,
	output logic                jump_target_rdy,
	output logic                jump_now,
	fetch_beat_if.source        beat,
	queue_head_if.stall         qstat
);
	import frontend_pkg::*;

	addr_t fetch_addr;
	logic  reset_holdoff;
	logic  addr_hold;
	pend_t pend_cnt;
	pend_t flush_cnt;
	logic  skip_low_hw;
	logic  req_vld;
	logic  req_issue;
	logic  req_accept;
	logic  fetch_stall;

	// The stall rule below relies on at least one entry of slack in the queue
	if (fifo_depth < 2) begin : g_depth_check
		$error("fetch_ctrl needs a prefetch queue of at least two entries");
	end

	// ----------------------------------------
	// Address phase
	// ----------------------------------------

	// A held request blocks jumps, since the address must not move before rdy
	assign jump_target_rdy = !addr_hold;
	assign jump_now        = jump_target_vld && jump_target_rdy;

	// Only registered state here, so rdy and data_vld never reach the address
	assign fetch_stall = qstat.full
		|| (qstat.almost_full && pend_cnt != '0)
		|| pend_cnt[1];

	always_comb begin
		mem_addr = fetch_addr;
		req_vld  = 1'b1;
		// While held, the address and vld just repeat the waiting request
		if (!addr_hold) begin
			if (jump_target_vld) begin
				// Jump target goes out in the same cycle when there is room
				mem_addr = {jump_target[w_addr-1:2], 2'b00};
				req_vld  = !pend_cnt[1];
			end else if (fetch_stall) begin
				req_vld = 1'b0;
			end
		end
	end

	// Bus stays quiet for the first cycle out of reset
	assign mem_addr_vld = req_vld && !reset_holdoff;
	assign req_issue    = mem_addr_vld && !addr_hold;
	assign req_accept   = mem_addr_vld && mem_addr_rdy;

	// Fetch address runs ahead of decode in whole words
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr <= reset_vector;
		end else if (jump_now) begin
			// Step past the target when it was accepted straight away
			fetch_addr <= {jump_target[w_addr-1:2] + (w_addr-2)'(req_accept), 2'b00};
		end else if (req_accept) begin
			fetch_addr <= fetch_addr + addr_t'(4);
		end
	end

	// ----------------------------------------
	// Bus tracking
	// ----------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reset_holdoff <= 1'b1;
			addr_hold     <= 1'b0;
			pend_cnt      <= '0;
			flush_cnt     <= '0;
		end else begin
			reset_holdoff <= 1'b0;
			addr_hold     <= mem_addr_vld && !mem_addr_rdy;
			// A request counts from its first cycle on the bus
			pend_cnt <= pend_cnt + pend_t'(req_issue) - pend_t'(mem_data_vld);
			if (jump_now) begin
				// Everything still in flight belongs to the old stream
				flush_cnt <= pend_cnt - pend_t'(mem_data_vld);
			end else if (flush_cnt != '0 && mem_data_vld) begin
				flush_cnt <= flush_cnt - pend_t'(1);
			end
		end
	end

	// A halfword-aligned jump means the lower half of the first new word is
	// not part of the program, so it is marked invalid
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			skip_low_hw <= 1'b0;
		end else if (jump_now) begin
			skip_low_hw <= extension_c && jump_target[1];
		end else if (beat.live) begin
			skip_low_hw <= 1'b0;
		end
	end

	assign beat.data  = mem_data;
	assign beat.err   = mem_data_err;
	assign beat.hwvld = {1'b1, !skip_low_hw};
	assign beat.live  = mem_data_vld && flush_cnt == '0 && !jump_now;

	// ----------------------------------------
	// Checks
	// ----------------------------------------

	flush_within_pend: assert property (@(posedge clk) disable iff (!rst_n)
		flush_cnt <= pend_cnt);

	pend_bounded: assert property (@(posedge clk) disable iff (!rst_n)
		pend_cnt <= pend_t'(2));

	no_orphan_data: assert property (@(posedge clk) disable iff (!rst_n)
		mem_data_vld |-> pend_cnt != '0);

	// A waiting request keeps its address until rdy
	req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		mem_addr_vld && !mem_addr_rdy |=> mem_addr_vld && $stable(mem_addr));

endmodule

// ==== fetch/prefetch_queue.sv ====
`timescale 1ns/1ps

module prefetch_queue #(
	parameter bit extension_c = 1'b1,
	parameter int fifo_depth  = 2
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        jump_now,
	fetch_beat_if.sink  beat,
	queue_head_if.head  head
);
	import frontend_pkg::*;

	word_t  q_data   [fifo_depth];
	logic   q_err    [fifo_depth];
	hwvld_t q_hwvld  [fifo_depth];
	word_t  up_data  [fifo_depth];
	logic   up_err   [fifo_depth];
	hwvld_t up_hwvld [fifo_depth];
	logic [fifo_depth-1:0] q_vld;
	logic [fifo_depth-1:0] up_vld;
	logic [fifo_depth-1:0] dn_vld;
	logic push;
	logic pop;

	// A bypassed beat is already in the CIR
	assign push = beat.live && !head.bypass;
	assign pop  = head.pop;

	// Neighbour views of each entry, with the top entry seeing the bus beat
	for (genvar i = 0; i < fifo_depth; i++) begin : g_entry
		assign q_vld[i] = extension_c ? |q_hwvld[i] : q_hwvld[i][0];
		if (i < fifo_depth - 1) begin : g_mid
			assign up_data[i]  = q_data[i+1];
			assign up_err[i]   = q_err[i+1];
			assign up_hwvld[i] = q_hwvld[i+1];
			assign up_vld[i]   = q_vld[i+1];
		end else begin : g_top
			assign up_data[i]  = beat.data;
			assign up_err[i]   = beat.err;
			assign up_hwvld[i] = '0;
			assign up_vld[i]   = 1'b0;
		end
		if (i == 0) begin : g_bottom
			assign dn_vld[i] = 1'b1;
		end else begin : g_upper
			assign dn_vld[i] = q_vld[i-1];
		end
	end

	// Payload moves down on a pop, and a new beat lands in any free slot
	always_ff @(posedge clk) begin
		for (int i = 0; i < fifo_depth; i++) begin
			if (pop || (push && !q_vld[i])) begin
				q_data[i] <= up_vld[i] ? up_data[i] : beat.data;
				q_err[i]  <= up_vld[i] ? up_err[i] : beat.err;
			end
		end
	end

	// Halfword tags carry the validity of each entry
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < fifo_depth; i++) begin
				q_hwvld[i] <= '0;
			end
		end else begin
			for (int i = 0; i < fifo_depth; i++) begin
				if (jump_now) begin
					q_hwvld[i] <= '0;
				end else if (up_vld[i] && pop) begin
					q_hwvld[i] <= up_hwvld[i];
				end else if (q_vld[i] && pop) begin
					// Top valid entry empties, or refills from the bus
					q_hwvld[i] <= push ? beat.hwvld : hwvld_t'(0);
				end else if (!q_vld[i] && dn_vld[i] && push && !pop) begin
					q_hwvld[i] <= beat.hwvld;
				end
			end
		end
	end

	assign head.head_data   = q_data[0];
	assign head.head_err    = q_err[0];
	assign head.head_hwvld  = q_hwvld[0];
	assign head.empty       = !q_vld[0];
	assign head.full        = q_vld[fifo_depth-1];
	assign head.almost_full = q_vld[fifo_depth-2];

	// Entries fill from the bottom, so the head is always entry 0
	vld_compact: assert property (@(posedge clk) disable iff (!rst_n)
		((q_vld >> 1) & ~q_vld) == '0);

	// Fetch throttling must leave room for every beat that comes back
	no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		push && head.full |-> pop);

endmodule

// ==== hw/frontend_top.sv ====
`timescale 1ns/1ps

module frontend_top #(
	parameter frontend_pkg::addr_t reset_vector = 32'h0000_0000,
	parameter bit                  extension_c  = 1'b1,
	parameter int                  fifo_depth   = 2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	output frontend_pkg::addr_t  mem_addr,
	output logic                 mem_addr_vld,
	input  logic                 mem_addr_rdy,
	input  frontend_pkg::word_t  mem_data,
	input  logic                 mem_data_err,
	input  logic                 mem_data_vld,
	input  frontend_pkg::addr_t  jump_target,
	input  logic                 jump_target_vld,
	output logic                 jump_target_rdy,
	output frontend_pkg::word_t  cir,
	output frontend_pkg::level_t cir_vld,
	input  frontend_pkg::level_t cir_use,
	output logic [1:0]           cir_err
);

	// Jump strobe shared by all three blocks
	logic jump_now;

	fetch_beat_if beat_if ();
	queue_head_if qhead_if ();

	// Request side and beat tagging
	fetch_ctrl #(
		.reset_vector (reset_vector),
		.extension_c  (extension_c),
		.fifo_depth   (fifo_depth)
	) fetch_ctrl_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data        (mem_data),
		.mem_data_err    (mem_data_err),
		.mem_data_vld    (mem_data_vld),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.jump_now        (jump_now),
		.beat            (beat_if.source),
		.qstat           (qhead_if.stall)
	);

	prefetch_queue #(
		.extension_c (extension_c),
		.fifo_depth  (fifo_depth)
	) prefetch_queue_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.jump_now (jump_now),
		.beat     (beat_if.sink),
		.head     (qhead_if.head)
	);

	// CIR for decode
	instr_assembly #(
		.extension_c (extension_c)
	) instr_assembly_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.jump_now (jump_now),
		.beat     (beat_if.sink),
		.head     (qhead_if.consumer),
		.cir      (cir),
		.cir_vld  (cir_vld),
		.cir_use  (cir_use),
		.cir_err  (cir_err)
	);

endmodule

// ==== hw/instr_assembly.sv ====
`timescale 1ns/1ps

module instr_assembly #(
	parameter bit extension_c = 1'b1
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 jump_now,
	fetch_beat_if.sink           beat,
	queue_head_if.consumer       head,
	output frontend_pkg::word_t  cir,
	output frontend_pkg::level_t cir_vld,
	input  frontend_pkg::level_t cir_use,
	output logic [1:0]           cir_err
);
	import frontend_pkg::*;

	// buf_level counts valid halfwords in {hwbuf, cir}
	level_t            buf_level;
	hw_t               hwbuf;
	logic [2:0]        err_q;
	word_t             fetch_data;
	hwvld_t            fetch_hwvld;
	logic              fetch_err;
	logic              fetch_vld;
	word_t             fetch_aligned;
	logic [3*w_hw-1:0] data_shifted;
	logic [3*w_hw-1:0] data_next;
	logic [2:0]        err_shifted;
	logic [2:0]        err_next;
	logic [2:0]        err_mask;
	level_t            level_kept;
	level_t            fill;
	level_t            level_next;
	logic              room;

	// Queue head has priority and an empty queue exposes the bus beat directly
	assign fetch_data  = head.empty ? beat.data : head.head_data;
	assign fetch_hwvld = head.empty ? beat.hwvld : head.head_hwvld;
	assign fetch_vld   = !head.empty || beat.live;
	assign fetch_err   = fetch_vld && (head.empty ? beat.err : head.head_err);

	// A word holding only its upper halfword is moved down to the bottom
	assign fetch_aligned = {
		fetch_data[w_data-1 -: w_hw],
		(fetch_hwvld[0] || !extension_c) ? fetch_data[w_hw-1:0] : fetch_data[w_data-1 -: w_hw]
	};

	// ----------------------------------------
	// Consume and refill
	// ----------------------------------------

	// Drop what decode used while garbage above the kept level stays unread
	always_comb begin
		if (cir_use[1]) begin
			data_shifted = {hwbuf, cir[w_data-1 -: w_hw], hwbuf};
			err_shifted  = err_q >> 2;
		end else if (cir_use[0] && extension_c) begin
			data_shifted = {hwbuf, hwbuf, cir[w_data-1 -: w_hw]};
			err_shifted  = err_q >> 1;
		end else begin
			data_shifted = {hwbuf, cir};
			err_shifted  = err_q;
		end
	end

	assign level_kept = buf_level - cir_use;

	// A half word needs one free slot less than a full one
	assign room = level_kept <= ((extension_c && !(&fetch_hwvld)) ? level_t'(2) : level_t'(1));

	assign head.pop    = room && !head.empty;
	assign head.bypass = room && head.empty && beat.live;

	// Fresh data goes on top of whatever halfwords are kept
	always_comb begin
		data_next = data_shifted;
		err_next  = err_shifted;
		if (room) begin
			if (level_kept[1] && extension_c) begin
				data_next = {fetch_aligned[w_hw-1:0], data_shifted[2*w_hw-1:0]};
				err_next  = {fetch_err, err_shifted[1:0]};
			end else if (level_kept[0] && extension_c) begin
				data_next = {fetch_aligned, data_shifted[w_hw-1:0]};
				err_next  = {{2{fetch_err}}, err_shifted[0]};
			end else begin
				data_next = {data_shifted[3*w_hw-1 -: w_hw], fetch_aligned};
				err_next  = {err_shifted[2], {2{fetch_err}}};
			end
		end
	end

	assign fill       = (room && fetch_vld) ? ((&fetch_hwvld) ? level_t'(2) : level_t'(1)) : '0;
	assign level_next = jump_now ? level_t'(0) : level_kept + fill;

	// Error flags only survive on halfwords that are actually held
	always_comb begin
		case (level_next)
			2'd0:    err_mask = 3'b000;
			2'd1:    err_mask = 3'b001;
			2'd2:    err_mask = 3'b011;
			default: err_mask = 3'b111;
		endcase
	end

	// ----------------------------------------
	// CIR registers
	// ----------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_level <= '0;
			cir_vld   <= '0;
			err_q     <= '0;
		end else begin
			buf_level <= level_next;
			// Decode sees at most one full 32-bit instruction
			cir_vld   <= (level_next > level_t'(2)) ? level_t'(2) : level_next;
			err_q     <= err_next & err_mask;
		end
	end

	always_ff @(posedge clk) begin
		{hwbuf, cir} <= data_next;
	end

	assign cir_err = err_q[1:0];

	use_within_vld: assert property (@(posedge clk) disable iff (!rst_n)
		cir_use <= cir_vld);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f --top-module tb_frontend \
	-o tb_frontend_sim; then
	echo "Verilator build failed"
	exit 1
fi

if ! sim_out=$(./obj_dir/tb_frontend_sim); then
	printf '%s\n' "$sim_out"
	echo "Simulation exited with an error"
	exit 1
fi
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qxF 'All tests passed!'; then
	exit 0
else
	exit 1
fi

// ==== sources.f ====
common/frontend_pkg.sv
common/fetch_beat_if.sv
common/queue_head_if.sv
fetch/fetch_ctrl.sv
fetch/prefetch_queue.sv
hw/instr_assembly.sv
hw/frontend_top.sv
tests/tb_frontend.sv

// ==== tests/tb_frontend.sv ====
`timescale 1ns/1ps

module tb_frontend;
	import frontend_pkg::*;

	localparam int clk_period   = 4;
	localparam int reset_cycles = 16;
	localparam int jump_cap     = 50;
	// Cycle budget of all tests together for the watchdog
	localparam int test_cycles  = 100 + 7 * jump_cap + 600 + 2000 + 3 * 300 + 600 + 600;
	localparam addr_t no_err    = 32'hffff_ffff;

	logic   clk;
	logic   rst_n;
	addr_t  mem_addr;
	logic   mem_addr_vld;
	logic   mem_addr_rdy;
	word_t  mem_data;
	logic   mem_data_err;
	logic   mem_data_vld;
	addr_t  jump_target;
	logic   jump_target_vld;
	logic   jump_target_rdy;
	word_t  cir;
	level_t cir_vld;
	level_t cir_use;
	logic [1:0] cir_err;

	// Requests wait here in the bus model until their return cycle
	addr_t req_addr[$];
	int    req_due[$];
	int    last_due;
	int    accepted;
	int    returned;
	logic  wait_prev;
	addr_t wait_addr;
	logic  first_seen;
	addr_t first_addr;
	logic  s_addr_vld;

	// Test controls
	logic [31:0] lfsr;
	logic        mode16;
	logic        rand_lat;
	logic        rand_rdy;
	logic [31:0] stall_mask;
	addr_t       err_addr;
	logic        err_check;
	int          err_seen;
	logic        jmp_pending;
	addr_t       jmp_addr;
	logic        jump_prev;
	word_t       dec_log[$];
	int          cyc;
	string       cur_test;
	int          test_errs;
	int          tests_run;
	int          tests_failed;
	int          total_errs;

	frontend_top #(
		.reset_vector (32'h0000_0100),
		.extension_c  (1'b1),
		.fifo_depth   (2)
	) dut_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data        (mem_data),
		.mem_data_err    (mem_data_err),
		.mem_data_vld    (mem_data_vld),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.cir             (cir),
		.cir_vld         (cir_vld),
		.cir_use         (cir_use),
		.cir_err         (cir_err)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Ends a run that got stuck somewhere
	initial begin
		#((reset_cycles + test_cycles) * clk_period + 1000);
		$display("Watchdog expired before the tests finished");
		$display("Test failures found");
		$finish;
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------

	// Galois LFSR that steps once per bit taken
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		return b;
	endfunction

	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_bit()};
		end
		return v;
	endfunction

	// Compressed opcode built from address bits 15..1 with low bits 00
	function automatic hw_t hw_at(input addr_t h);
		return 16'({h[15:1], 2'b00});
	endfunction

	// Content of the word at a word-aligned byte address
	function automatic word_t word_at(input addr_t a);
		if (mode16) begin
			return {hw_at(a + 32'd2), hw_at(a)};
		end
		return {a[15:0], a[15:2], 2'b11};
	endfunction

	task automatic report_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		$display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
		test_errs++;
	endtask

	task automatic report_fail(input string msg);
		$display("%s: %s", cur_test, msg);
		test_errs++;
	endtask

	// ----------------------------------------
	// Bus and decode models
	// ----------------------------------------

	// Runs at 1 ns after the rising edge, where registered outputs are settled
	task automatic drive_inputs();
		level_t     len;
		logic [1:0] exp_err;
		mem_data_vld = 1'b0;
		mem_data     = '0;
		mem_data_err = 1'b0;
		if (req_addr.size() > 0 && req_due[0] <= cyc) begin
			mem_data_vld = 1'b1;
			mem_data     = word_at(req_addr[0]);
			mem_data_err = (req_addr[0] == err_addr);
			void'(req_addr.pop_front());
			void'(req_due.pop_front());
			returned++;
		end
		mem_addr_rdy    = rand_rdy ? (lfsr_bit() | lfsr_bit()) : 1'b1;
		jump_target_vld = jmp_pending;
		jump_target     = jmp_addr;
		if (jump_prev && cir_vld !== 2'd0)
			report_value("cir_vld after jump", 32'd0, 32'(cir_vld));
		if (err_check && cir_vld != 2'd0) begin
			exp_err[0] = ({cir[15:2], 2'b00} == err_addr[15:0]);
			exp_err[1] = (cir_vld == 2'd2) && (cir[31:16] == err_addr[15:0]);
			if ((cir_err & (cir_vld == 2'd2 ? 2'b11 : 2'b01)) !== exp_err)
				report_value("cir_err", 32'(exp_err), 32'(cir_err));
			if (exp_err[0])
				err_seen++;
		end
		// Decode takes a whole instruction or nothing
		cir_use = 2'd0;
		len = (cir[1:0] == 2'b11) ? 2'd2 : 2'd1;
		if (cir_vld >= len && !stall_mask[cyc % 32])
			cir_use = len;
	endtask

	// Runs at the falling edge, where combinational outputs are settled
	task automatic sample_outputs();
		int due;
		if (wait_prev && (!mem_addr_vld || mem_addr !== wait_addr))
			report_fail("request changed while waiting for mem_addr_rdy");
		if (jump_target_rdy !== !wait_prev)
			report_fail("jump_target_rdy does not follow the request hold");
		wait_prev  = mem_addr_vld && !mem_addr_rdy;
		wait_addr  = mem_addr;
		s_addr_vld = mem_addr_vld;
		if (mem_addr_vld && mem_addr_rdy) begin
			due = cyc + (rand_lat ? 1 + int'(lfsr_bits(2)) % 3 : 1);
			// Beats return in request order
			if (due <= last_due)
				due = last_due + 1;
			last_due = due;
			req_addr.push_back(mem_addr);
			req_due.push_back(due);
			accepted++;
			if (!first_seen) begin
				first_seen = 1'b1;
				first_addr = mem_addr;
			end
		end
		if (accepted - returned > 2)
			report_fail("more than two fetches outstanding");
		if (cir_use != 2'd0)
			dec_log.push_back(cir_use == 2'd2 ? cir : {16'h0, cir[15:0]});
		jump_prev = 1'b0;
		if (jump_target_vld && jump_target_rdy) begin
			if (mem_addr_vld && mem_addr !== {jump_target[31:2], 2'b00})
				report_value("jump address", {jump_target[31:2], 2'b00}, mem_addr);
			jmp_pending = 1'b0;
			jump_prev   = 1'b1;
			// Only instructions of the new stream count from here on
			dec_log.delete();
		end
	endtask

	task automatic tick();
		drive_inputs();
		@(negedge clk);
		sample_outputs();
		@(posedge clk);
		#1;
		cyc++;
	endtask

	task automatic do_jump(input addr_t target);
		int n;
		n = 0;
		jmp_addr    = target;
		jmp_pending = 1'b1;
		while (jmp_pending && n < jump_cap) begin
			tick();
			n++;
		end
		if (jmp_pending) begin
			report_fail("jump was never accepted");
			jmp_pending = 1'b0;
		end
	endtask

	task automatic run_until(input int n, input int cap);
		int k;
		k = 0;
		while (dec_log.size() < n && k < cap) begin
			tick();
			k++;
		end
		if (dec_log.size() < n)
			report_fail($sformatf("only %0d of %0d instructions decoded", dec_log.size(), n));
	endtask

	task automatic check_stream(input addr_t start, input int n);
		word_t exp;
		for (int i = 0; i < n && i < dec_log.size(); i++) begin
			exp = mode16 ? {16'h0, hw_at(start + 32'(2 * i))} : word_at(start + 32'(4 * i));
			if (dec_log[i] !== exp)
				report_value($sformatf("instr %0d", i), exp, dec_log[i]);
		end
	endtask

	task automatic begin_test(input string name, input logic m16, input logic rnd);
		cur_test   = name;
		test_errs  = 0;
		mode16     = m16;
		rand_lat   = rnd;
		rand_rdy   = rnd;
		stall_mask = '0;
	endtask

	task automatic end_test();
		tests_run++;
		total_errs += test_errs;
		if (test_errs == 0) begin
			$display("%s: PASS", cur_test);
		end else begin
			tests_failed++;
			$display("%s: FAIL with %0d errors", cur_test, test_errs);
		end
	endtask

	// ----------------------------------------
	// Tests
	// ----------------------------------------

	task automatic test_reset();
		int n;
		n = 0;
		begin_test("reset", 1'b0, 1'b0);
		stall_mask = '1;
		if (cir_vld !== 2'd0)
			report_value("cir_vld", 32'd0, 32'(cir_vld));
		tick();
		if (s_addr_vld !== 1'b0)
			report_value("mem_addr_vld", 32'd0, 32'(s_addr_vld));
		while (!first_seen && n < 100) begin
			tick();
			n++;
		end
		if (!first_seen)
			report_fail("no fetch request was accepted");
		else if (first_addr !== 32'h0000_0100)
			report_value("first address", 32'h0000_0100, first_addr);
		end_test();
	endtask

	task automatic test_stream(input string name, input logic m16, input addr_t start);
		begin_test(name, m16, 1'b0);
		do_jump(start);
		run_until(64, 600);
		check_stream(start, 64);
		end_test();
	endtask

	task automatic test_random();
		begin_test("random_stall", 1'b0, 1'b1);
		// Never stall every cycle, so decode always moves on
		stall_mask = lfsr_bits(32) & 32'h7777_7777;
		do_jump(32'h0000_0400);
		run_until(64, 2000);
		check_stream(32'h0000_0400, 64);
		end_test();
	endtask

	task automatic test_jump();
		addr_t targets[3];
		targets = '{32'h0000_0800, 32'h0000_0a00, 32'h0000_0c02};
		begin_test("jump_flush", 1'b1, 1'b1);
		// Later jumps land while earlier fetches are still in flight
		foreach (targets[i]) begin
			do_jump(targets[i]);
			run_until(12, 300);
			check_stream(targets[i], 12);
		end
		end_test();
	endtask

	task automatic test_error();
		begin_test("bus_error", 1'b0, 1'b0);
		err_addr = 32'h0000_1010;
		err_seen = 0;
		do_jump(32'h0000_1000);
		err_check = 1'b1;
		run_until(16, 600);
		err_check = 1'b0;
		check_stream(32'h0000_1000, 16);
		if (err_seen == 0)
			report_fail("the faulting word never reached the CIR");
		err_addr = no_err;
		end_test();
	endtask

	initial begin
		rst_n           = 1'b0;
		mem_addr_rdy    = 1'b0;
		mem_data        = '0;
		mem_data_err    = 1'b0;
		mem_data_vld    = 1'b0;
		jump_target     = '0;
		jump_target_vld = 1'b0;
		cir_use         = '0;
		lfsr            = 32'h6308_4f7c;
		err_addr        = no_err;
		err_check       = 1'b0;
		jmp_pending     = 1'b0;
		jmp_addr        = '0;
		jump_prev       = 1'b0;
		wait_prev       = 1'b0;
		wait_addr       = '0;
		first_seen      = 1'b0;
		first_addr      = '0;
		last_due        = 0;
		accepted        = 0;
		returned        = 0;
		cyc             = 0;
		tests_run       = 0;
		tests_failed    = 0;
		total_errs      = 0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset();
		test_stream("stream32", 1'b0, 32'h0000_0200);
		test_random();
		test_jump();
		test_stream("stream16", 1'b1, 32'h0000_0e00);
		test_error();
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
		if (tests_failed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
